// ==== files.f ====
+incdir+verif
logic/alu_pkg.sv
logic/arith_logic_unit.sv
logic/shift_rotate_unit.sv
logic/single_operand_unit.sv
logic/mul_div_unit.sv
logic/alu_writeback.sv
logic/alu_core.sv
verif/alu_core_tb.sv

// ==== verif/alu_vectors.svh ====
`ifndef ALU_VECTORS_SVH
`define ALU_VECTORS_SVH

// Each row holds op, size, signed flag, operand1, operand2, preset CCR (xnzvc),
// expected result, expected CCR (xnzvc) and expected div_trap
typedef struct packed {
    alu_op_t           op;
    size_t             size;
    logic              sgn;
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
    ccr_t              pre;
    logic [WORD_W-1:0] res;
    ccr_t              flags;
    logic              trap;
} vector_t;

localparam int NUM_VECTORS = 43;

localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{OP_ADD,  SIZE_L, 1'b0, 32'h7FFFFFFF, 32'h00000001, 5'b00000, 32'h80000000, 5'b01010, 1'b0},
    '{OP_ADD,  SIZE_B, 1'b0, 32'h000000FF, 32'h00000001, 5'b00000, 32'h00000100, 5'b10101, 1'b0},
    '{OP_SUB,  SIZE_W, 1'b0, 32'h00000000, 32'h00000001, 5'b00000, 32'hFFFFFFFF, 5'b11001, 1'b0},
    '{OP_SUB,  SIZE_B, 1'b0, 32'h00000080, 32'h00000001, 5'b00000, 32'h0000007F, 5'b00010, 1'b0},
    // CMP keeps the previous result and X
    '{OP_CMP,  SIZE_L, 1'b0, 32'h00000005, 32'h00000005, 5'b10000, 32'h0000007F, 5'b10100, 1'b0},
    '{OP_CMP,  SIZE_B, 1'b0, 32'h00000001, 32'h00000002, 5'b00000, 32'h0000007F, 5'b01001, 1'b0},
    '{OP_AND,  SIZE_L, 1'b0, 32'hF0F0F0F0, 32'h0FF00FF0, 5'b11111, 32'h00F000F0, 5'b10000, 1'b0},
    '{OP_OR,   SIZE_W, 1'b0, 32'h12340000, 32'h00008000, 5'b00000, 32'h12348000, 5'b01000, 1'b0},
    '{OP_EOR,  SIZE_B, 1'b0, 32'h000000AA, 32'h000000AA, 5'b00000, 32'h00000000, 5'b00100, 1'b0},
    // Extended forms with X as carry and a sticky Z
    '{OP_ADDX, SIZE_L, 1'b0, 32'h00000001, 32'h00000001, 5'b10100, 32'h00000003, 5'b00000, 1'b0},
    '{OP_ADDX, SIZE_B, 1'b0, 32'h000000FF, 32'h00000000, 5'b10100, 32'h00000100, 5'b10101, 1'b0},
    '{OP_SUBX, SIZE_W, 1'b0, 32'h00000000, 32'h00000000, 5'b10000, 32'hFFFFFFFF, 5'b11001, 1'b0},
    '{OP_SUBX, SIZE_L, 1'b0, 32'h00000005, 32'h00000004, 5'b10100, 32'h00000000, 5'b00100, 1'b0},
    // One-bit shift and rotate steps
    '{OP_LSL,  SIZE_B, 1'b0, 32'h00000081, 32'h00000000, 5'b00000, 32'h00000102, 5'b10001, 1'b0},
    '{OP_ASL,  SIZE_W, 1'b0, 32'h00004000, 32'h00000000, 5'b00000, 32'h00008000, 5'b01010, 1'b0},
    '{OP_ROL,  SIZE_L, 1'b0, 32'h80000001, 32'h00000000, 5'b10000, 32'h00000003, 5'b10001, 1'b0},
    '{OP_ROXL, SIZE_B, 1'b0, 32'h00000080, 32'h00000000, 5'b10000, 32'h00000101, 5'b10001, 1'b0},
    '{OP_LSR,  SIZE_W, 1'b0, 32'h00008001, 32'h00000000, 5'b00000, 32'h00004000, 5'b10001, 1'b0},
    '{OP_ASR,  SIZE_L, 1'b0, 32'h80000002, 32'h00000000, 5'b00000, 32'hC0000001, 5'b01000, 1'b0},
    '{OP_ROR,  SIZE_B, 1'b0, 32'h00000002, 32'h00000000, 5'b10000, 32'h00000001, 5'b10000, 1'b0},
    '{OP_ROXR, SIZE_L, 1'b0, 32'h00000001, 32'h00000000, 5'b10000, 32'h80000000, 5'b11001, 1'b0},
    '{OP_LSL,  SIZE_L, 1'b0, 32'h80000000, 32'h00000000, 5'b00000, 32'h00000000, 5'b10101, 1'b0},
    // Single-operand group
    '{OP_NEG,  SIZE_B, 1'b0, 32'h00000001, 32'h00000000, 5'b00000, 32'hFFFFFFFF, 5'b11001, 1'b0},
    '{OP_NEG,  SIZE_L, 1'b0, 32'h80000000, 32'h00000000, 5'b00000, 32'h80000000, 5'b11011, 1'b0},
    '{OP_NEGX, SIZE_W, 1'b0, 32'h00000000, 32'h00000000, 5'b10100, 32'hFFFFFFFF, 5'b11001, 1'b0},
    '{OP_NEGX, SIZE_L, 1'b0, 32'h00000000, 32'h00000000, 5'b00100, 32'h00000000, 5'b00100, 1'b0},
    '{OP_NOT,  SIZE_W, 1'b0, 32'h0000FFFF, 32'h00000000, 5'b10000, 32'hFFFF0000, 5'b10100, 1'b0},
    '{OP_CLR,  SIZE_B, 1'b0, 32'h12345678, 32'h00000000, 5'b00000, 32'h00000000, 5'b00100, 1'b0},
    '{OP_SWAP, SIZE_W, 1'b0, 32'h1234ABCD, 32'h00000000, 5'b00000, 32'hABCD1234, 5'b01000, 1'b0},
    '{OP_EXTW, SIZE_L, 1'b0, 32'h12340080, 32'h00000000, 5'b00000, 32'h1234FF80, 5'b01000, 1'b0},
    '{OP_EXTL, SIZE_W, 1'b0, 32'hFFFF7FFF, 32'h00000000, 5'b00000, 32'h00007FFF, 5'b00000, 1'b0},
    '{OP_MOVE, SIZE_B, 1'b0, 32'h12345600, 32'h00000000, 5'b10011, 32'h12345600, 5'b10100, 1'b0},
    // Multiply on the low halves
    '{OP_MUL,  SIZE_W, 1'b0, 32'h0000FFFF, 32'h0000FFFF, 5'b00000, 32'hFFFE0001, 5'b01000, 1'b0},
    '{OP_MUL,  SIZE_W, 1'b1, 32'h0000FFFF, 32'h0000FFFF, 5'b00000, 32'h00000001, 5'b00000, 1'b0},
    '{OP_MUL,  SIZE_W, 1'b1, 32'hABCD8000, 32'h00007FFF, 5'b00000, 32'hC0008000, 5'b01000, 1'b0},
    // Divide with the remainder in the high half
    '{OP_DIV,  SIZE_L, 1'b0, 32'h00000064, 32'h00000007, 5'b00000, 32'h0002000E, 5'b00000, 1'b0},
    '{OP_DIV,  SIZE_L, 1'b0, 32'h00010000, 32'h00000001, 5'b00000, 32'h0002000E, 5'b01010, 1'b1},
    '{OP_DIV,  SIZE_L, 1'b1, 32'hFFFFFF9C, 32'h00000007, 5'b00000, 32'hFFFEFFF2, 5'b01000, 1'b0},
    '{OP_DIV,  SIZE_L, 1'b1, 32'h00000064, 32'h0000FFF9, 5'b00000, 32'h0002FFF2, 5'b01000, 1'b0},
    '{OP_DIV,  SIZE_L, 1'b1, 32'h00008000, 32'h00000001, 5'b00000, 32'h0002FFF2, 5'b01010, 1'b1},
    '{OP_MUL,  SIZE_W, 1'b0, 32'h00000002, 32'h00000003, 5'b00000, 32'h00000006, 5'b00000, 1'b0},
    '{OP_DIV,  SIZE_L, 1'b0, 32'h00001234, 32'hFFFF0000, 5'b11111, 32'h00000006, 5'b10000, 1'b1},
    '{OP_MUL,  SIZE_W, 1'b1, 32'h0000FFFF, 32'h00000001, 5'b00000, 32'hFFFFFFFF, 5'b01000, 1'b0}
};

`endif

// ==== verif/alu_core_tb.sv ====
module alu_core_tb import alu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD    = 8;
    localparam int READY_TIMEOUT = DIV_STEPS + 8;

    `include "alu_vectors.svh"

    logic              clock;
    logic              reset_n;
    alu_cmd_t          cmd;
    logic [WORD_W-1:0] operand1;
    logic [WORD_W-1:0] operand2;
    logic [WORD_W-1:0] result;
    ccr_t              ccr;
    logic              md_ready;
    logic              div_trap;

    int vector_index;

    alu_core uut (
        .clock    (clock),
        .reset_n  (reset_n),
        .cmd      (cmd),
        .operand1 (operand1),
        .operand2 (operand2),
        .result   (result),
        .ccr      (ccr),
        .md_ready (md_ready),
        .div_trap (div_trap)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic check_value(input string name, input logic [WORD_W-1:0] actual,
                               input logic [WORD_W-1:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] vector %0d %s: got %h, expected %h",
                     vector_index, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic drive_cmd(input alu_op_t op, input size_t size, input logic sgn,
                             input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b);
        cmd      <= '{op: op, size: size, signed_md: sgn};
        operand1 <= a;
        operand2 <= b;
    endtask

    // Polls on falling edges until the divider reports ready
    task automatic wait_md_ready();
        int count;
        count = 0;
        while (md_ready !== 1'b1) begin
            if (count >= READY_TIMEOUT) begin
                $display("Divider never raised md_ready on vector %0d", vector_index);
                $display("TEST FAILED");
                $fatal(1, "Timeout waiting for md_ready");
            end
            @(negedge clock);
            count++;
        end
    endtask

    task automatic apply_vector(input int idx);
        vector_t v;
        logic    long_div;
        v        = VECTORS[idx];
        long_div = (v.op == OP_DIV) && (v.b[HALF_W-1:0] != '0);
        vector_index = idx;

        // Preset the flags through a CCR load
        @(posedge clock);
        drive_cmd(OP_CCR_LOAD, SIZE_L, 1'b0, WORD_W'(v.pre), '0);
        @(posedge clock);
        drive_cmd(v.op, v.size, v.sgn, v.a, v.b);
        @(negedge clock);
        check_value("ccr after load", WORD_W'(ccr), WORD_W'(v.pre));

        // Single-cycle ops and a zero divisor resolve on this edge
        @(posedge clock);
        if (long_div) begin
            @(negedge clock);
            check_value("md_ready", WORD_W'(md_ready), WORD_W'(1'b0));
            wait_md_ready();
            @(posedge clock);
        end
        drive_cmd(OP_NONE, SIZE_L, 1'b0, '0, '0);
        @(negedge clock);

        check_value("result", result, v.res);
        check_value("ccr", WORD_W'(ccr), WORD_W'(v.flags));
        check_value("div_trap", WORD_W'(div_trap), WORD_W'(v.trap));
        check_value("md_ready", WORD_W'(md_ready), WORD_W'(1'b1));
    endtask

    initial begin
        clock        = 1'b0;
        reset_n      = 1'b0;
        cmd          = '{op: OP_NONE, size: SIZE_L, signed_md: 1'b0};
        operand1     = '0;
        operand2     = '0;
        vector_index = -1;

        repeat (3) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);

        // Idle state straight out of reset
        check_value("result", result, '0);
        check_value("ccr", WORD_W'(ccr), WORD_W'(CCR_RESET));
        check_value("div_trap", WORD_W'(div_trap), WORD_W'(1'b0));
        check_value("md_ready", WORD_W'(md_ready), WORD_W'(1'b1));

        for (int i = 0; i < NUM_VECTORS; i++) begin
            apply_vector(i);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== logic/alu_core.sv ====
module alu_core import alu_pkg::*; (
    input  logic              clock,
    input  logic              reset_n,
    input  alu_cmd_t          cmd,
    input  logic [WORD_W-1:0] operand1,
    input  logic [WORD_W-1:0] operand2,
    output logic [WORD_W-1:0] result,
    output ccr_t              ccr,
    output logic              md_ready,
    output logic              div_trap
);

    unit_out_t alu_out;
    unit_out_t shift_out;
    unit_out_t single_out;
    unit_out_t md_out;

    // All units see the same command and operands
    arith_logic_unit u_arith (
        .cmd      (cmd),
        .operand1 (operand1),
        .operand2 (operand2),
        .ccr      (ccr),
        .unit_out (alu_out)
    );

    shift_rotate_unit u_shift (
        .cmd      (cmd),
        .operand1 (operand1),
        .ccr      (ccr),
        .unit_out (shift_out)
    );

    single_operand_unit u_single (
        .cmd      (cmd),
        .operand1 (operand1),
        .ccr      (ccr),
        .unit_out (single_out)
    );

    mul_div_unit u_mul_div (
        .clock    (clock),
        .reset_n  (reset_n),
        .cmd      (cmd),
        .operand1 (operand1),
        .operand2 (operand2),
        .ccr      (ccr),
        .unit_out (md_out),
        .md_ready (md_ready),
        .div_trap (div_trap)
    );

    // Result and CCR registers live here
    alu_writeback u_writeback (
        .clock      (clock),
        .reset_n    (reset_n),
        .alu_out    (alu_out),
        .shift_out  (shift_out),
        .single_out (single_out),
        .md_out     (md_out),
        .result     (result),
        .ccr        (ccr)
    );

endmodule

// ==== logic/alu_writeback.sv ====
module alu_writeback import alu_pkg::*; (
    input  logic              clock,
    input  logic              reset_n,
    input  unit_out_t         alu_out,
    input  unit_out_t         shift_out,
    input  unit_out_t         single_out,
    input  unit_out_t         md_out,
    output logic [WORD_W-1:0] result,
    output ccr_t              ccr
);

    unit_out_t units [0:3];
    unit_out_t sel;

    assign units = '{alu_out, shift_out, single_out, md_out};

    // At most one unit claims, so OR of the claimed outputs is the selection
    always_comb begin
        sel = '0;
        for (int i = 0; i < 4; i++) begin
            if (units[i].hit) begin
                sel = sel | units[i];
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            result <= '0;
            ccr    <= CCR_RESET;
        end else if (sel.hit) begin
            ccr <= sel.ccr;
            // CMP and CCR load leave the result alone
            if (sel.write_result) begin
                result <= sel.value;
            end
        end
    end

endmodule

// ==== logic/mul_div_unit.sv ====
module mul_div_unit import alu_pkg::*; (
    input  logic              clock,
    input  logic              reset_n,
    input  alu_cmd_t          cmd,
    input  logic [WORD_W-1:0] operand1,
    input  logic [WORD_W-1:0] operand2,
    input  ccr_t              ccr,
    output unit_out_t         unit_out,
    output logic              md_ready,
    output logic              div_trap
);

    logic signed [HALF_W:0]     mul_a;
    logic signed [HALF_W:0]     mul_b;
    logic signed [2*HALF_W+1:0] product;

    logic [DIV_CNT_W-1:0] div_count;
    logic [WORD_W-1:0]    dividend;
    logic [WORD_W-1:0]    divisor;
    logic [HALF_W:0]      quotient;
    logic [WORD_W:0]      div_diff;
    logic                 is_mul;
    logic                 is_div;
    logic                 dividend_neg;
    logic                 divisor_neg;
    logic                 quotient_neg;
    logic                 div_zero;
    logic                 div_load;
    logic                 div_done;
    logic                 div_overflow;
    logic [HALF_W-1:0]    div_quotient;
    logic [HALF_W-1:0]    div_remainder;

    assign is_mul = cmd.op == OP_MUL;
    assign is_div = cmd.op == OP_DIV;

    // 17-bit operands cover both signed and unsigned halves
    assign mul_a   = {operand1[HALF_W-1] & cmd.signed_md, operand1[HALF_W-1:0]};
    assign mul_b   = {operand2[HALF_W-1] & cmd.signed_md, operand2[HALF_W-1:0]};
    assign product = mul_a * mul_b;

    // Count of 0 is idle, 1 is waiting for the result read
    assign div_zero = is_div && div_count == '0 && operand2[HALF_W-1:0] == '0;
    assign div_load = is_div && div_count == '0 && !div_zero;
    assign div_done = is_div && div_count == 1;
    assign md_ready = div_count <= 1;

    assign dividend_neg = cmd.signed_md & operand1[WORD_W-1];
    assign divisor_neg  = cmd.signed_md & operand2[HALF_W-1];
    assign quotient_neg = dividend_neg ^ divisor_neg;

    assign div_diff = {1'b0, dividend} - {1'b0, divisor};

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            div_count <= '0;
        end else if (div_load) begin
            div_count <= DIV_CNT_W'(DIV_STEPS + 1);
        end else if (div_count > 1) begin
            div_count <= div_count - 1'b1;
        end else if (div_done) begin
            div_count <= '0;
        end
    end

    // Restoring division on magnitudes
    always_ff @(posedge clock) begin
        if (div_load) begin
            quotient <= '0;
            dividend <= dividend_neg ? -operand1 : operand1;
            divisor  <= {divisor_neg ? -operand2[HALF_W-1:0] : operand2[HALF_W-1:0],
                         {HALF_W{1'b0}}};
        end else if (div_count > 1) begin
            if (!div_diff[WORD_W]) begin
                dividend <= div_diff[WORD_W-1:0];
                quotient <= {quotient[HALF_W-1:0], 1'b1};
            end else begin
                quotient <= {quotient[HALF_W-1:0], 1'b0};
            end
            divisor <= divisor >> 1;
        end
    end

    // Signed quotient must stay within -32768 to 32767
    assign div_overflow = quotient[HALF_W] ||
        (cmd.signed_md && ((!quotient_neg && quotient[HALF_W-1]) ||
        (quotient_neg && quotient[HALF_W-1:0] > HALF_W'(1 << (HALF_W - 1)))));

    assign div_quotient  = quotient_neg ? -quotient[HALF_W-1:0] : quotient[HALF_W-1:0];
    assign div_remainder = dividend_neg ? -dividend[HALF_W-1:0] : dividend[HALF_W-1:0];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            div_trap <= 1'b0;
        end else if (div_zero || (div_done && div_overflow)) begin
            div_trap <= 1'b1;
        end else if (is_mul || div_done) begin
            div_trap <= 1'b0;
        end
    end

    always_comb begin
        unit_out.hit          = is_mul || div_zero || div_done;
        unit_out.write_result = is_mul || (div_done && !div_overflow);
        unit_out.value        = is_mul ? product[WORD_W-1:0] : {div_remainder, div_quotient};
        unit_out.ccr.x        = ccr.x;
        unit_out.ccr.c        = 1'b0;
        if (is_mul) begin
            unit_out.ccr.n = product[WORD_W-1];
            unit_out.ccr.z = product[WORD_W-1:0] == '0;
            unit_out.ccr.v = 1'b0;
        end else if (div_done && !div_overflow) begin
            unit_out.ccr.n = div_quotient[HALF_W-1];
            unit_out.ccr.z = div_quotient == '0;
            unit_out.ccr.v = 1'b0;
        end else if (div_done) begin
            // Overflow reports V and N
            unit_out.ccr.n = 1'b1;
            unit_out.ccr.z = 1'b0;
            unit_out.ccr.v = 1'b1;
        end else begin
            unit_out.ccr.n = 1'b0;
            unit_out.ccr.z = 1'b0;
            unit_out.ccr.v = 1'b0;
        end
    end

endmodule

// ==== logic/single_operand_unit.sv ====
module single_operand_unit import alu_pkg::*; (
    input  alu_cmd_t          cmd,
    input  logic [WORD_W-1:0] operand1,
    input  ccr_t              ccr,
    output unit_out_t         unit_out
);

    logic              hit;
    logic              is_neg;
    size_t             flag_size;
    logic [WORD_W-1:0] res;
    logic              dm;
    logic              rm;
    logic              zero;

    always_comb begin
        hit       = 1'b1;
        flag_size = cmd.size;
        case (cmd.op)
            OP_MOVE, OP_CCR_LOAD: res = operand1;
            OP_NEG:               res = -operand1;
            OP_NEGX:              res = -operand1 - WORD_W'(ccr.x);
            OP_NOT:               res = ~operand1;
            OP_CLR:               res = '0;
            OP_SWAP: begin
                res       = {operand1[HALF_W-1:0], operand1[WORD_W-1:HALF_W]};
                flag_size = SIZE_L;
            end
            OP_EXTW: begin
                res       = {operand1[WORD_W-1:HALF_W], {8{operand1[7]}}, operand1[7:0]};
                flag_size = SIZE_W;
            end
            OP_EXTL: begin
                res       = {{HALF_W{operand1[HALF_W-1]}}, operand1[HALF_W-1:0]};
                flag_size = SIZE_L;
            end
            default: begin
                hit = 1'b0;
                res = '0;
            end
        endcase
    end

    assign is_neg = cmd.op inside {OP_NEG, OP_NEGX};
    assign dm     = msb_at(operand1, flag_size);
    assign rm     = msb_at(res, flag_size);
    assign zero   = zero_at(res, flag_size);

    always_comb begin
        unit_out.hit          = hit;
        unit_out.write_result = cmd.op != OP_CCR_LOAD;
        unit_out.value        = res;
        if (cmd.op == OP_CCR_LOAD) begin
            unit_out.ccr = ccr_t'(operand1[$bits(ccr_t)-1:0]);
        end else begin
            // Borrow out of zero whenever either sign bit is set
            unit_out.ccr.x = is_neg ? (dm | rm) : ccr.x;
            unit_out.ccr.n = rm;
            unit_out.ccr.z = (cmd.op == OP_NEGX) ? (ccr.z & zero) : zero;
            unit_out.ccr.v = is_neg & dm & rm;
            unit_out.ccr.c = is_neg & (dm | rm);
        end
    end

endmodule

// ==== logic/shift_rotate_unit.sv ====
module shift_rotate_unit import alu_pkg::*; (
    input  alu_cmd_t          cmd,
    input  logic [WORD_W-1:0] operand1,
    input  ccr_t              ccr,
    output unit_out_t         unit_out
);

    logic              hit;
    logic              left;
    logic              dm;
    logic              fill;
    logic              out_bit;
    logic [WORD_W-1:0] res;
    logic              rm;

    assign left = cmd.op inside {OP_LSL, OP_ASL, OP_ROL, OP_ROXL};
    assign hit  = left || (cmd.op inside {OP_LSR, OP_ASR, OP_ROR, OP_ROXR});
    assign dm   = msb_at(operand1, cmd.size);

    // Bit entering the vacated position
    always_comb begin
        case (cmd.op)
            OP_ROL, OP_ASR:   fill = dm;
            OP_ROR:           fill = operand1[0];
            OP_ROXL, OP_ROXR: fill = ccr.x;
            default:          fill = 1'b0;
        endcase
    end

    always_comb begin
        if (left) begin
            res = {operand1[WORD_W-2:0], fill};
        end else begin
            res = operand1 >> 1;
            res[WORD_W-1] = fill;
            // Right steps also fill at the size's top bit
            if (cmd.size == SIZE_W) begin
                res[HALF_W-1] = fill;
            end
            if (cmd.size == SIZE_B) begin
                res[7] = fill;
            end
        end
    end

    assign out_bit = left ? dm : operand1[0];
    assign rm      = msb_at(res, cmd.size);

    always_comb begin
        unit_out.hit          = hit;
        unit_out.write_result = 1'b1;
        unit_out.value        = res;
        unit_out.ccr.x = (cmd.op inside {OP_ROL, OP_ROR}) ? ccr.x : out_bit;
        unit_out.ccr.n = rm;
        unit_out.ccr.z = zero_at(res, cmd.size);
        // Sign change on this step only
        unit_out.ccr.v = (cmd.op == OP_ASL) && (rm != dm);
        unit_out.ccr.c = out_bit;
    end

endmodule

// ==== logic/arith_logic_unit.sv ====
module arith_logic_unit import alu_pkg::*; (
    input  alu_cmd_t          cmd,
    input  logic [WORD_W-1:0] operand1,
    input  logic [WORD_W-1:0] operand2,
    input  ccr_t              ccr,
    output unit_out_t         unit_out
);

    logic              hit;
    logic              is_add;
    logic              is_sub;
    logic              extend;
    logic [WORD_W-1:0] res;
    logic              sm;
    logic              dm;
    logic              rm;
    logic              zero;
    logic              carry;
    logic              overflow;

    // operand1 is the destination, operand2 the source
    always_comb begin
        hit = 1'b1;
        case (cmd.op)
            OP_ADD:         res = operand1 + operand2;
            OP_ADDX:        res = operand1 + operand2 + WORD_W'(ccr.x);
            OP_SUB, OP_CMP: res = operand1 - operand2;
            OP_SUBX:        res = operand1 - operand2 - WORD_W'(ccr.x);
            OP_AND:         res = operand1 & operand2;
            OP_OR:          res = operand1 | operand2;
            OP_EOR:         res = operand1 ^ operand2;
            default: begin
                hit = 1'b0;
                res = '0;
            end
        endcase
    end

    assign is_add = cmd.op inside {OP_ADD, OP_ADDX};
    assign is_sub = cmd.op inside {OP_SUB, OP_SUBX, OP_CMP};
    assign extend = cmd.op inside {OP_ADDX, OP_SUBX};

    // Sign bits at the operand size
    assign sm   = msb_at(operand2, cmd.size);
    assign dm   = msb_at(operand1, cmd.size);
    assign rm   = msb_at(res, cmd.size);
    assign zero = zero_at(res, cmd.size);

    always_comb begin
        if (is_add) begin
            carry    = (sm & dm) | (~rm & dm) | (sm & ~rm);
            overflow = (sm & dm & ~rm) | (~sm & ~dm & rm);
        end else if (is_sub) begin
            carry    = (sm & ~dm) | (rm & ~dm) | (sm & rm);
            overflow = (~sm & dm & ~rm) | (sm & ~dm & rm);
        end else begin
            carry    = 1'b0;
            overflow = 1'b0;
        end
    end

    always_comb begin
        unit_out.hit          = hit;
        unit_out.write_result = cmd.op != OP_CMP;
        unit_out.value        = res;
        // CMP and the logic group keep X
        unit_out.ccr.x = ((is_add || is_sub) && cmd.op != OP_CMP) ? carry : ccr.x;
        unit_out.ccr.n = rm;
        // Extended forms only ever clear Z
        unit_out.ccr.z = extend ? (ccr.z & zero) : zero;
        unit_out.ccr.v = overflow;
        unit_out.ccr.c = carry;
    end

endmodule

// ==== logic/alu_pkg.sv ====
package alu_pkg;

    // Datapath widths
    localparam int WORD_W    = 32;
    localparam int HALF_W    = 16;
    localparam int DIV_STEPS = 17;

    // Divider counter covers idle, wait and every step
    localparam int DIV_CNT_W = $clog2(DIV_STEPS + 2);

    typedef enum logic [4:0] {
        OP_NONE,
        OP_ADD, OP_SUB, OP_CMP, OP_AND, OP_OR, OP_EOR,
        OP_ADDX, OP_SUBX,
        OP_LSL, OP_ASL, OP_ROL, OP_ROXL,
        OP_LSR, OP_ASR, OP_ROR, OP_ROXR,
        OP_MOVE, OP_NEG, OP_NEGX, OP_NOT, OP_CLR,
        OP_SWAP, OP_EXTW, OP_EXTL, OP_CCR_LOAD,
        OP_MUL, OP_DIV
    } alu_op_t;

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_W,
        SIZE_L
    } size_t;

    typedef struct packed {
        alu_op_t op;
        size_t   size;
        logic    signed_md;
    } alu_cmd_t;

    // Same bit order as the 68000 CCR with X at bit 4 down to C at bit 0
    typedef struct packed {
        logic x;
        logic n;
        logic z;
        logic v;
        logic c;
    } ccr_t;

    typedef struct packed {
        logic              hit;
        logic              write_result;
        logic [WORD_W-1:0] value;
        ccr_t              ccr;
    } unit_out_t;

    localparam ccr_t CCR_RESET = '0;

    // Sign bit of a value at the operand size
    function automatic logic msb_at(logic [WORD_W-1:0] value, size_t size);
        case (size)
            SIZE_B:  return value[7];
            SIZE_W:  return value[HALF_W-1];
            default: return value[WORD_W-1];
        endcase
    endfunction

    // Zero test at the operand size
    function automatic logic zero_at(logic [WORD_W-1:0] value, size_t size);
        case (size)
            SIZE_B:  return value[7:0] == '0;
            SIZE_W:  return value[HALF_W-1:0] == '0;
            default: return value == '0;
        endcase
    endfunction

endpackage
